/* src/mem_pkg.sv */
`default_nettype none

// storage geometry of the memory subsystem
// everything that describes the RAM itself lives here, the control
// encodings are kept in ctrl_pkg
package mem_pkg;

    // one memory word is the native width of the teaching CPU
    localparam int WORD_W = 32;

    // number of words in the RAM
    localparam int MEM_DEPTH = 512;

    // word address width follows from the depth, 9 bits for 512 words
    localparam int ADDR_W = $clog2(MEM_DEPTH);

    // hex image read at elaboration, one word per line starting at address 0
    localparam string MEM_INIT_FILE = "mem_image.hex";

    // a single memory word as it sits in the RAM, the MDR and on rdata
    typedef logic [WORD_W-1:0] word_t;

    // a word address as held by the MAR
    typedef logic [ADDR_W-1:0] mem_addr_t;

endpackage

`default_nettype wire

/* src/ctrl_pkg.sv */
`default_nettype none

// control side encodings shared by the sequencer, the port registers and the top
package ctrl_pkg;

    // the command carries an address and a data word, so the storage types are needed
    import mem_pkg::*;

    // sequencer states, one per edge of the fixed access walk
    // idle waits for a request, load fills MAR and MDR,
    // access strobes the RAM, capture moves the read word into the MDR
    typedef enum logic [1:0] {
        SEQ_IDLE    = 2'd0,
        SEQ_LOAD    = 2'd1,
        SEQ_ACCESS  = 2'd2,
        SEQ_CAPTURE = 2'd3
    } seq_state_e;

    // command presented by the CPU side, 42 bits in all
    typedef struct packed {
        // high for a store, low for a load
        logic      write;
        mem_addr_t addr;
        word_t     wdata;
    } mem_cmd_t;

    // one-cycle strobes from the sequencer to the port registers and the RAM
    typedef struct packed {
        logic mar_load;
        logic mdr_load_cmd;
        logic mdr_load_ram;
        logic ram_write;
        logic ram_read;
    } mem_strobes_t;

    // all strobes inactive, the value after reset and between accesses
    localparam mem_strobes_t STROBES_NONE = '0;

endpackage

`default_nettype wire

/* src/ram.sv */
`timescale 1ns/1ps
`default_nettype none

// single port synchronous RAM with a registered read port
// the array is preloaded with the program image at elaboration
module ram
    import mem_pkg::*;
(
    input  wire logic      clk,
    input  wire mem_addr_t addr,
    input  wire word_t     wdata,
    input  wire logic      write_enable,
    input  wire logic      read_enable,
    output word_t          q
);

    // the storage array, one word per address
    word_t mem [MEM_DEPTH];

    // preload of the program image
    // every word is cleared first because the image only covers the low addresses
    // and the rest of the array has to read back as zero
    initial begin
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
        $readmemh(MEM_INIT_FILE, mem);
    end

    // write port
    // the word on wdata lands in the array on the edge where write enable is high
    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[addr] <= wdata;
        end
    end

    // read port
    // the output register only moves when read enable is high,
    // otherwise it keeps the last word that was read
    // a read and a write to the same address on one edge returns the old word,
    // the sequencer never issues both at once
    always_ff @(posedge clk) begin
        if (read_enable) begin
            q <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* src/mem_port.sv */
`timescale 1ns/1ps
`default_nettype none

// memory address register and memory data register in front of the RAM
// both registers only move on a strobe from the sequencer
module mem_port
    import mem_pkg::*;
    import ctrl_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         arst_n,
    input  wire mem_strobes_t strobes,
    input  wire mem_cmd_t     cmd_q,
    input  wire word_t        ram_q,
    output mem_addr_t         mar,
    output word_t             mdr
);

    // value the MDR takes on the next edge
    word_t mdr_next;

    // MDR source selection
    // the RAM output wins over the command data, though the sequencer never
    // raises both load strobes in the same cycle
    // with neither strobe active the MDR keeps its contents, which is what
    // lets rdata hold between accesses
    always_comb begin
        mdr_next = mdr;
        if (strobes.mdr_load_ram) begin
            mdr_next = ram_q;
        end else if (strobes.mdr_load_cmd) begin
            mdr_next = cmd_q.wdata;
        end
    end

    // MAR
    // it takes the latched address one edge after the request was accepted
    // and then holds it through the RAM access
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mar <= '0;
        end else if (strobes.mar_load) begin
            mar <= cmd_q.addr;
        end
    end

    // MDR
    // on a store it holds the word to be written and keeps it afterwards,
    // so the CPU sees its own store data while done is high
    // on a load it is refilled from the RAM output register in the capture step
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mdr <= '0;
        end else begin
            mdr <= mdr_next;
        end
    end

endmodule

`default_nettype wire

/* src/mem_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

// access sequencer of the memory path
// a one-cycle request is turned into a fixed walk of three edges
// load, access and capture, each edge driven by strobes registered one edge earlier
module mem_sequencer
    import mem_pkg::*;
    import ctrl_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire logic     req,
    input  wire mem_cmd_t cmd,
    output mem_cmd_t      cmd_q,
    output mem_strobes_t  strobes,
    output logic          busy,
    output logic          done
);

    seq_state_e   state;
    seq_state_e   state_next;
    mem_strobes_t strobes_next;
    logic         busy_next;
    logic         done_next;
    logic         accept;

    // a request only counts while no access is in flight
    // pulses that arrive during busy are dropped without any trace
    assign accept = req && !busy;

    // next state and next strobes
    // the strobes are decoded one edge ahead and registered, so the port
    // registers and the RAM see clean levels for a whole cycle
    always_comb begin
        state_next   = state;
        strobes_next = STROBES_NONE;
        busy_next    = busy;
        done_next    = 1'b0;

        case (state)
            SEQ_IDLE: begin
                if (accept) begin
                    // the latched command is not there yet, so the incoming
                    // write bit decides whether the MDR takes the store data
                    strobes_next.mar_load     = 1'b1;
                    strobes_next.mdr_load_cmd = cmd.write;
                    busy_next                 = 1'b1;
                    state_next                = SEQ_LOAD;
                end
            end

            SEQ_LOAD: begin
                // MAR and MDR are loaded on this edge, the RAM goes next
                strobes_next.ram_write = cmd_q.write;
                strobes_next.ram_read  = !cmd_q.write;
                state_next             = SEQ_ACCESS;
            end

            SEQ_ACCESS: begin
                // a load still has to move the RAM output into the MDR
                // a store leaves the MDR alone so it keeps the written word
                strobes_next.mdr_load_ram = !cmd_q.write;
                state_next                = SEQ_CAPTURE;
            end

            SEQ_CAPTURE: begin
                // the access ends on this edge
                done_next  = 1'b1;
                busy_next  = 1'b0;
                state_next = SEQ_IDLE;
            end

            default: begin
                state_next = SEQ_IDLE;
                busy_next  = 1'b0;
            end
        endcase
    end

    // control registers
    // done is registered, so it is high for exactly the one cycle after capture
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= SEQ_IDLE;
            strobes <= STROBES_NONE;
            busy    <= 1'b0;
            done    <= 1'b0;
        end else begin
            state   <= state_next;
            strobes <= strobes_next;
            busy    <= busy_next;
            done    <= done_next;
        end
    end

    // command latch
    // it is captured only on the accepting edge and stays stable for the
    // whole walk, whatever the CPU side does with cmd meanwhile
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= cmd;
        end
    end

endmodule

`default_nettype wire

/* src/mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

// memory subsystem of the teaching CPU
// the sequencer steers the MAR and MDR, which in turn address and feed the RAM
module mem_subsystem
    import mem_pkg::*;
    import ctrl_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire logic     req,
    input  wire mem_cmd_t cmd,
    output logic          busy,
    output logic          done,
    output word_t         rdata
);

    mem_cmd_t     cmd_q;
    mem_strobes_t strobes;
    mem_addr_t    mar;
    word_t        mdr;
    word_t        ram_q;

    // the CPU reads the MDR directly
    assign rdata = mdr;

    mem_sequencer u_sequencer (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .cmd     (cmd),
        .cmd_q   (cmd_q),
        .strobes (strobes),
        .busy    (busy),
        .done    (done)
    );

    mem_port u_port (
        .clk     (clk),
        .arst_n  (arst_n),
        .strobes (strobes),
        .cmd_q   (cmd_q),
        .ram_q   (ram_q),
        .mar     (mar),
        .mdr     (mdr)
    );

    // the RAM is addressed by the MAR and always writes the MDR
    ram u_ram (
        .clk          (clk),
        .addr         (mar),
        .wdata        (mdr),
        .write_enable (strobes.ram_write),
        .read_enable  (strobes.ram_read),
        .q            (ram_q)
    );

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// free running testbench clock with a 40 ns period
module tb_clock_gen (
    output logic clk
);

    // half of the 40 ns period
    localparam int HALF_PERIOD = 20;

    // the clock starts low so the first rising edge comes at 20 ns
    initial begin
        clk = 1'b0;
    end

    always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

/* verification/mem_subsystem_props.sv */
`timescale 1ns/1ps
`default_nettype none

// protocol properties of the memory subsystem, bound into the top level
// fail_count holds the number of property failures seen so far
module mem_subsystem_props
    import mem_pkg::*;
(
    input wire logic  clk,
    input wire logic  arst_n,
    input wire logic  req,
    input wire logic  busy,
    input wire logic  done,
    input wire word_t rdata
);

    int   fail_count = 0;
    logic accept;

    // same acceptance rule as the sequencer uses
    assign accept = req && !busy;

    // done is a single cycle pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !done)
        else begin
            fail_count++;
            $error("done stayed high for more than one cycle");
        end

    // busy covers the three edges of the walk and done follows right after it
    done_three_edges: assert property (@(posedge clk) disable iff (!arst_n)
        accept |=> (busy && !done) [*3] ##1 (done && !busy))
        else begin
            fail_count++;
            $error("done did not follow three edges after an accepted request");
        end

    // busy only rises on an edge that saw a request
    busy_from_accept: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(busy) |-> $past(req))
        else begin
            fail_count++;
            $error("busy rose without a request");
        end

    // busy only falls together with the done pulse
    busy_until_done: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(busy) |-> done)
        else begin
            fail_count++;
            $error("busy fell without done");
        end

    // the MDR only moves inside an access or in the capture that ends it
    rdata_stable: assert property (@(posedge clk) disable iff (!arst_n)
        !$stable(rdata) |-> (busy || done))
        else begin
            fail_count++;
            $error("rdata changed outside an access");
        end

endmodule

bind mem_subsystem mem_subsystem_props u_props (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .busy   (busy),
    .done   (done),
    .rdata  (rdata)
);

`default_nettype wire

/* verification/tb_mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

// testbench of the memory subsystem
// requests go out on falling edges and results are sampled there too,
// when every register output has settled since the last rising edge
module tb_mem_subsystem
    import mem_pkg::*;
    import ctrl_pkg::*;
();

    // an access takes four cycles, so this leaves a wide margin
    localparam int DONE_TIMEOUT = 20;

    logic     clk;
    logic     arst_n;
    logic     req;
    mem_cmd_t cmd;
    logic     busy;
    logic     done;
    word_t    rdata;

    // reference copy of the RAM contents, updated on every write
    word_t model [MEM_DEPTH];
    int    seed;
    int    value_errors;
    int    protocol_errors;
    int    assertion_errors;

    tb_clock_gen clock_src (
        .clk (clk)
    );

    mem_subsystem uut (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .cmd    (cmd),
        .busy   (busy),
        .done   (done),
        .rdata  (rdata)
    );

    // the program image holds four words at the bottom and zero everywhere else
    function automatic word_t image_word(input int addr);
        case (addr)
            0: return 32'h0880_0002;
            1: return 32'h0808_0000;
            2: return 32'h0100_0068;
            3: return 32'h0917_fffc;
            default: return '0;
        endcase
    endfunction

    // a mismatch on rdata produces an ERR line with both values
    task automatic check_rdata(input word_t expected);
        assert (rdata === expected) else begin
            value_errors++;
            $display("ERR t=%0t rdata expected %08h actual %08h", $time, expected, rdata);
        end
    endtask

    // polls done on falling edges until it shows up or the timeout runs out
    // with hold set the MDR has to keep its old word while busy is high
    task automatic wait_done(input logic hold, input word_t held);
        int cycles;
        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT) begin
            if (hold && busy) begin
                check_rdata(held);
            end
            @(negedge clk);
            cycles++;
        end
        assert (done) else begin
            protocol_errors++;
            $display("timeout because done did not arrive within %0d cycles", DONE_TIMEOUT);
        end
    endtask

    // one complete access that starts and ends on a falling edge
    // the caller returns in the done cycle, so the next request is back to back
    task automatic run_access(input logic write, input mem_addr_t addr, input word_t wdata);
        word_t held;
        held      = rdata;
        cmd.write = write;
        cmd.addr  = addr;
        cmd.wdata = wdata;
        req       = 1'b1;
        @(negedge clk);
        req = 1'b0;
        assert (busy) else begin
            protocol_errors++;
            $display("the request to address %03h was not accepted", addr);
        end
        // a load leaves the previous word on rdata until the capture edge
        wait_done(!write, held);
        if (write) begin
            model[addr] = wdata;
        end
        // on a write the MDR still holds the stored word
        check_rdata(model[addr]);
    endtask

    // idle cycles with no request, where rdata must hold and nothing may start
    task automatic idle_check(input int cycles, input word_t held);
        repeat (cycles) begin
            @(negedge clk);
            check_rdata(held);
            assert (!done && !busy) else begin
                protocol_errors++;
                $display("done or busy was raised while no request was pending");
            end
        end
    endtask

    // a write whose walk is hit by two more request pulses to another address
    // both pulses must be dropped, so only the first write may land
    task automatic busy_pulses(input mem_addr_t addr, input word_t wdata, input mem_addr_t other);
        cmd.write = 1'b1;
        cmd.addr  = addr;
        cmd.wdata = wdata;
        req       = 1'b1;
        @(negedge clk);
        // req stays high into the load edge with a changed command
        cmd.addr  = other;
        cmd.wdata = ~wdata;
        @(negedge clk);
        req = 1'b0;
        @(negedge clk);
        // a second pulse lands on the capture edge, where busy is still high
        req = 1'b1;
        @(negedge clk);
        req = 1'b0;
        wait_done(1'b0, '0);
        model[addr] = wdata;
        check_rdata(wdata);
        idle_check(4, wdata);
        run_access(1'b0, other, '0);
        run_access(1'b0, addr, '0);
    endtask

    initial begin
        mem_addr_t addr;
        word_t     data;
        int        gap;

        seed             = 21;
        value_errors     = 0;
        protocol_errors  = 0;
        assertion_errors = 0;
        req              = 1'b0;
        cmd              = '0;
        arst_n           = 1'b0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            model[i] = image_word(i);
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // reset state, then the very first idle cycle takes a request
        check_rdata('0);
        assert (!busy && !done) else begin
            protocol_errors++;
            $display("busy or done was high right after reset");
        end

        // the preloaded program words and one address nothing writes to
        for (int a = 0; a < 4; a++) begin
            run_access(1'b0, mem_addr_t'(a), '0);
        end
        run_access(1'b0, 9'h1a5, '0);

        // random writes, each read back at its own address and a neighbor
        for (int i = 0; i < 40; i++) begin
            addr = mem_addr_t'($random(seed));
            data = $random(seed);
            gap  = $unsigned($random(seed)) % 3;
            run_access(1'b1, addr, data);
            idle_check(gap, data);
            run_access(1'b0, addr, '0);
            run_access(1'b0, addr + 9'd1, '0);
        end

        busy_pulses(9'h0f0, 32'hcafe_0123, 9'h0f1);

        // a few quiet cycles let the bound properties finish their last checks
        idle_check(4, model[9'h0f0]);
        assertion_errors = uut.u_props.fail_count;

        $display("errors: %0d value, %0d protocol, %0d assertion",
                 value_errors, protocol_errors, assertion_errors);
        if (value_errors + protocol_errors + assertion_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mem_image.hex */
// one 32-bit word per line in hex, addresses 0 to 7
08800002
08080000
01000068
0917FFFC
00000000
00000000
00000000
00000000

/* mem_subsystem.f */
src/mem_pkg.sv
src/ctrl_pkg.sv
src/ram.sv
src/mem_port.sv
src/mem_sequencer.sv
src/mem_subsystem.sv
verification/tb_clock_gen.sv
verification/mem_subsystem_props.sv
verification/tb_mem_subsystem.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - files:
      - src/mem_pkg.sv
      - src/ctrl_pkg.sv
      - src/ram.sv
      - src/mem_port.sv
      - src/mem_sequencer.sv
      - src/mem_subsystem.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/mem_subsystem_props.sv
      - verification/tb_mem_subsystem.sv
